// File: bpu.f
+incdir+.
bpu_pkg.sv
ret_pc_ram.sv
ras.sv
branch_predecode.sv
next_pc_select.sv
bpu_top.sv
bpu_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = bpu_tb
RTL_TOP    = bpu_top
FILELIST   = bpu.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LOG        = sim.log
FAIL_MSG   = ** FAIL **
PASS_MSG   = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF -- '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF -- '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module bpu_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int RAS_SIZE     = `BPU_RAS_SIZE;
    localparam int NUM_TESTS    = 6;
    localparam logic [31:0] RET_WORD = 32'h03e00008; // JR $31.

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] exp_pc;
        logic        exp_taken;
        logic [3:0]  test;
    } entry_t;

    logic           clk;
    logic           resetn;
    logic           fetch_valid;
    bpu_pkg::addr_t fetch_pc;
    logic [31:0]    fetch_instr;
    logic           pred_valid;
    bpu_pkg::addr_t pred_pc;
    logic           pred_taken;

    entry_t      table_q[$];
    int          table_len = 0;
    logic [31:0] lfsr;
    logic [31:0] next_fetch; // Fetch follows the predicted path.
    int          errors;
    int          checks;
    int          tests_passed;
    int          tests_failed;
    int          test_err [1:NUM_TESTS];

    // Reference return stack.
    logic [31:0] stk [RAS_SIZE];
    int          stk_top;
    bit          stk_empty;
    int          stk_ovf;

    bpu_top DUT (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .pred_valid  (pred_valid),
        .pred_pc     (pred_pc),
        .pred_taken  (pred_taken)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic model_push(input logic [31:0] ret);
        if (stk_empty) begin
            stk_empty = 1'b0;
        end else if (stk_top == RAS_SIZE - 1) begin
            if (stk_ovf < 2 * RAS_SIZE - 1) begin
                stk_ovf++; // Full, the top slot is overwritten.
            end
        end else begin
            stk_top++;
        end
        stk[stk_top] = ret;
    endtask

    task automatic model_pop();
        if (stk_ovf > 0) begin
            stk_ovf--;
        end else if (!stk_empty) begin
            if (stk_top == 0) begin
                stk_empty = 1'b1;
            end else begin
                stk_top--;
            end
        end
    endtask

    function automatic logic [31:0] region_target(input logic [31:0] pc,
                                                  input logic [25:0] idx);
        logic [31:0] pc4;
        pc4 = pc + 32'd4;
        return {pc4[31:28], idx, 2'b00};
    endfunction

    task automatic add_entry(input int test, input bit valid, input logic [31:0] instr,
                             input logic [31:0] exp_pc, input bit exp_taken);
        entry_t e;
        e.valid     = valid;
        e.pc        = next_fetch;
        e.instr     = instr;
        e.exp_pc    = exp_pc;
        e.exp_taken = exp_taken;
        e.test      = 4'(test);
        table_q.push_back(e);
        if (valid) begin
            next_fetch = exp_pc;
        end
    endtask

    task automatic add_plain(input int test);
        logic [31:0] w;
        take_bits(32, w);
        w[31:29] = 3'b001; // Immediate ALU group, never a branch.
        add_entry(test, 1'b1, w, next_fetch + 32'd4, 1'b0);
    endtask

    task automatic add_jump(input int test, input logic [25:0] idx);
        add_entry(test, 1'b1, {6'h02, idx}, region_target(next_fetch, idx), 1'b1);
    endtask

    task automatic add_call(input int test, input logic [25:0] idx);
        model_push(next_fetch + 32'd4);
        add_entry(test, 1'b1, {6'h03, idx}, region_target(next_fetch, idx), 1'b1);
    endtask

    task automatic add_ret(input int test);
        if (stk_empty || stk_ovf != 0) begin
            add_entry(test, 1'b1, RET_WORD, next_fetch + 32'd4, 1'b0);
        end else begin
            add_entry(test, 1'b1, RET_WORD, stk[stk_top], 1'b1);
        end
        model_pop();
    endtask

    task automatic add_cond(input int test, input logic [15:0] off);
        logic [31:0] target;
        target = next_fetch + 32'd4 + {{14{off[15]}}, off, 2'b00};
        if (target < next_fetch) begin
            add_entry(test, 1'b1, {6'h04, 5'd2, 5'd3, off}, target, 1'b1);
        end else begin
            add_entry(test, 1'b1, {6'h04, 5'd2, 5'd3, off}, next_fetch + 32'd4, 1'b0);
        end
    endtask

    task automatic add_indirect(input int test, input logic [31:0] instr);
        add_entry(test, 1'b1, instr, next_fetch + 32'd4, 1'b0);
    endtask

    task automatic add_idle(input int test, input logic [31:0] instr);
        add_entry(test, 1'b0, instr, 32'd0, 1'b0);
    endtask

    task automatic build_table();
        next_fetch = 32'h00400000;
        for (int k = 0; k < 4; k++) begin
            add_plain(1);
        end
        add_jump(2, 26'h0100040);
        add_plain(2);
        add_cond(2, 16'hfff8); // Backward.
        add_plain(2);
        add_cond(2, 16'h0006);
        add_call(2, 26'h0100200);
        add_plain(2);
        add_ret(2);
        add_call(3, 26'h0110000);
        add_plain(3);
        add_call(3, 26'h0120000);
        add_plain(3);
        add_call(3, 26'h0130000);
        add_plain(3);
        for (int k = 0; k < 3; k++) begin
            add_ret(3);
        end
        add_ret(4); // Stack is empty here.
        add_indirect(4, 32'h00a00008);
        add_indirect(4, {6'h00, 5'd9, 5'd0, 5'd31, 5'd0, 6'h09});
        add_plain(4);
        for (int k = 0; k < RAS_SIZE + 2; k++) begin
            add_call(5, 26'(32'h0200000 + k * 64));
        end
        for (int k = 0; k < RAS_SIZE + 4; k++) begin
            add_ret(5);
        end
        add_plain(6);
        add_idle(6, {6'h03, 26'h0300000}); // Call word that is not fetched.
        add_plain(6);
        add_idle(6, RET_WORD);
        add_idle(6, 32'h0);
        add_call(6, 26'h0310000);
        add_idle(6, RET_WORD);
        add_plain(6);
        add_ret(6);
        add_plain(6);
        add_ret(6); // Stack is empty again unless the idle call was pushed.
    endtask

    task automatic note_error(input int test);
        errors++;
        test_err[test]++;
    endtask

    task automatic check_reset();
        checks++;
        assert (pred_valid === 1'b0) else begin
            $display("pred_valid is high right after reset");
            note_error(1);
        end
        assert (pred_pc === `BPU_RESET_PC) else begin
            $display("** Error: pred_pc = %h, expected %h after reset", pred_pc, `BPU_RESET_PC);
            note_error(1);
        end
        assert (pred_taken === 1'b0) else begin
            $display("** Error: pred_taken = %h, expected %h after reset", pred_taken, 1'b0);
            note_error(1);
        end
    endtask

    task automatic check_entry(input entry_t e);
        checks++;
        if (!e.valid) begin
            assert (pred_valid === 1'b0) else begin
                $display("pred_valid raised after an idle fetch cycle");
                note_error(int'(e.test));
            end
        end else begin
            assert (pred_valid === 1'b1) else begin
                $display("No prediction one cycle after the fetch at %h", e.pc);
                note_error(int'(e.test));
            end
            assert (pred_pc === e.exp_pc) else begin
                $display("** Error: pred_pc = %h, expected %h (fetch_pc %h)",
                         pred_pc, e.exp_pc, e.pc);
                note_error(int'(e.test));
            end
            assert (pred_taken === e.exp_taken) else begin
                $display("** Error: pred_taken = %h, expected %h (fetch_pc %h)",
                         pred_taken, e.exp_taken, e.pc);
                note_error(int'(e.test));
            end
        end
    endtask

    task automatic report_test(input int test);
        if (test_err[test] == 0) begin
            tests_passed++;
            $display("Test %0d passed", test);
        end else begin
            tests_failed++;
            $display("Test %0d failed with %0d errors", test, test_err[test]);
        end
    endtask

    initial begin : main
        entry_t e;
        clk          = 1'b0;
        resetn       = 1'b0;
        fetch_valid  = 1'b0;
        fetch_pc     = '0;
        fetch_instr  = '0;
        lfsr         = 32'hd6c27a92;
        errors       = 0;
        checks       = 0;
        tests_passed = 0;
        tests_failed = 0;
        stk_top      = 0;
        stk_empty    = 1'b1;
        stk_ovf      = 0;
        foreach (test_err[t]) begin
            test_err[t] = 0;
        end
        build_table();
        table_len = table_q.size();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_reset();
        for (int i = 0; i < table_len; i++) begin
            e           = table_q[i];
            fetch_valid = e.valid;
            fetch_pc    = e.pc;
            fetch_instr = e.instr;
            @(negedge clk);
            check_entry(e);
            if (i == table_len - 1 || table_q[i + 1].test != e.test) begin
                report_test(int'(e.test));
            end
        end
        fetch_valid = 1'b0;
        $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_len > 0);
        #((table_len + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout, the stimulus table did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           fetch_valid,
    input  wire bpu_pkg::addr_t fetch_pc,
    input  wire logic [31:0]    fetch_instr,
    output logic                pred_valid,
    output bpu_pkg::addr_t      pred_pc,
    output logic                pred_taken
);

    bpu_pkg::branch_kind_e br_kind;
    bpu_pkg::addr_t        br_target;
    logic                  ras_push;
    logic                  ras_pop;
    bpu_pkg::addr_t        ret_pc_push;
    bpu_pkg::addr_t        ret_pc_pop;
    logic                  ras_fail;

    branch_predecode u_predecode (
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .br_kind     (br_kind),
        .br_target   (br_target),
        .ras_push    (ras_push),
        .ras_pop     (ras_pop),
        .ret_pc_push (ret_pc_push)
    );

    ras u_ras (
        .clk         (clk),
        .resetn      (resetn),
        .push        (ras_push),
        .pop         (ras_pop),
        .ret_pc_push (ret_pc_push),
        .ret_pc_pop  (ret_pc_pop),
        .fail        (ras_fail)
    );

    next_pc_select u_next_pc (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .br_kind     (br_kind),
        .br_target   (br_target),
        .ret_pc      (ret_pc_pop),
        .ras_fail    (ras_fail),
        .pred_valid  (pred_valid),
        .pred_pc     (pred_pc),
        .pred_taken  (pred_taken)
    );

endmodule

`default_nettype wire

// File: next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module next_pc_select (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic                  fetch_valid,
    input  wire bpu_pkg::addr_t        fetch_pc,
    input  wire bpu_pkg::branch_kind_e br_kind,
    input  wire bpu_pkg::addr_t        br_target,
    input  wire bpu_pkg::addr_t        ret_pc,
    input  wire logic                  ras_fail,
    output logic                       pred_valid,
    output bpu_pkg::addr_t             pred_pc,
    output logic                       pred_taken
);

    bpu_pkg::addr_t seq_pc;
    bpu_pkg::addr_t next_pc;
    logic           taken;

    assign seq_pc = fetch_pc + `BPU_ADDR_W'd4;

    always_comb begin
        next_pc = seq_pc;
        taken   = 1'b0;
        case (br_kind)
            bpu_pkg::BR_JUMP,
            bpu_pkg::BR_CALL: begin
                next_pc = br_target;
                taken   = 1'b1;
            end
            bpu_pkg::BR_COND: begin
                if (br_target < fetch_pc) begin // Backward taken, likely a loop.
                    next_pc = br_target;
                    taken   = 1'b1;
                end
            end
            bpu_pkg::BR_RET: begin
                if (!ras_fail) begin
                    next_pc = ret_pc;
                    taken   = 1'b1;
                end
            end
            default: begin
                next_pc = seq_pc; // Indirect targets are unknown here.
                taken   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pred_valid <= 1'b0;
            pred_pc    <= `BPU_RESET_PC;
            pred_taken <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;
            if (fetch_valid) begin
                pred_pc    <= next_pc;
                pred_taken <= taken;
            end
        end
    end

endmodule

`default_nettype wire

// File: branch_predecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module branch_predecode (
    input  wire logic            fetch_valid,
    input  wire bpu_pkg::addr_t  fetch_pc,
    input  wire logic [31:0]     fetch_instr,
    output bpu_pkg::branch_kind_e br_kind,
    output bpu_pkg::addr_t       br_target,
    output logic                 ras_push,
    output logic                 ras_pop,
    output bpu_pkg::addr_t       ret_pc_push
);

    bpu_pkg::opcode_e opcode;
    bpu_pkg::funct_e  funct;
    logic [4:0]       rs;
    logic [15:0]      imm;
    logic [25:0]      index;
    bpu_pkg::addr_t   pc_plus4;
    bpu_pkg::addr_t   jump_target;
    bpu_pkg::addr_t   cond_target;

    assign opcode = bpu_pkg::opcode_e'(fetch_instr[31:26]);
    assign funct  = bpu_pkg::funct_e'(fetch_instr[5:0]);
    assign rs     = fetch_instr[25:21];
    assign imm    = fetch_instr[15:0];
    assign index  = fetch_instr[25:0];

    // No delay slot, so the link address is the next word.
    assign pc_plus4 = fetch_pc + `BPU_ADDR_W'd4;

    // J-type target stays inside the 256 MB region of the next word.
    assign jump_target = {pc_plus4[`BPU_ADDR_W-1 -: 4], index, 2'b00};

    assign cond_target = pc_plus4 + {{(`BPU_ADDR_W-18){imm[15]}}, imm, 2'b00};

    always_comb begin
        br_kind = bpu_pkg::BR_NONE;
        case (opcode)
            bpu_pkg::OP_SPECIAL: begin
                if (funct == bpu_pkg::FN_JR) begin
                    if (rs == 5'd31) begin
                        br_kind = bpu_pkg::BR_RET;
                    end else begin
                        br_kind = bpu_pkg::BR_INDIRECT;
                    end
                end else if (funct == bpu_pkg::FN_JALR) begin
                    br_kind = bpu_pkg::BR_INDIRECT; // Register target, no link on the stack.
                end
            end
            bpu_pkg::OP_J: begin
                br_kind = bpu_pkg::BR_JUMP;
            end
            bpu_pkg::OP_JAL: begin
                br_kind = bpu_pkg::BR_CALL;
            end
            bpu_pkg::OP_BEQ,
            bpu_pkg::OP_BNE,
            bpu_pkg::OP_BLEZ,
            bpu_pkg::OP_BGTZ: begin
                br_kind = bpu_pkg::BR_COND;
            end
            default: begin
                br_kind = bpu_pkg::BR_NONE;
            end
        endcase
    end

    always_comb begin
        if (br_kind == bpu_pkg::BR_COND) begin
            br_target = cond_target;
        end else begin
            br_target = jump_target;
        end
    end

    // Stack traffic only for a word that is really fetched.
    assign ras_push    = fetch_valid && (br_kind == bpu_pkg::BR_CALL);
    assign ras_pop     = fetch_valid && (br_kind == bpu_pkg::BR_RET);
    assign ret_pc_push = pc_plus4;

endmodule

`default_nettype wire

// File: ras.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module ras #(
    parameter int RAS_SIZE = `BPU_RAS_SIZE
) (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           push,
    input  wire logic           pop,
    input  wire bpu_pkg::addr_t ret_pc_push,
    output bpu_pkg::addr_t      ret_pc_pop,
    output logic                fail
);

    localparam int PTR_W = $clog2(RAS_SIZE);
    localparam int OVF_W = PTR_W + 1;

    // Top is zero both for an empty stack and for a single entry.
    logic [PTR_W-1:0] top;
    logic [PTR_W-1:0] top_nxt;
    logic [PTR_W-1:0] ram_addr;
    logic             empty;
    logic             empty_nxt;
    logic             full;
    logic [OVF_W-1:0] ovf_cnt;
    logic [OVF_W-1:0] ovf_cnt_nxt;

    assign full = ~empty & (&top);

    always_comb begin
        empty_nxt = empty;
        if (push) begin
            empty_nxt = 1'b0;
        end else if (pop && ~(|ovf_cnt) && (top == '0)) begin
            empty_nxt = 1'b1; // Last real entry leaves.
        end
    end

    always_comb begin
        top_nxt = top;
        if (push) begin
            if (~empty && ~full) begin
                top_nxt = top + 1'b1;
            end
        end else if (pop) begin
            // Overflowed pops consume the overwritten slot, not the pointer.
            if (~(|ovf_cnt) && ~empty && (top != '0)) begin
                top_nxt = top - 1'b1;
            end
        end
    end

    always_comb begin
        ovf_cnt_nxt = ovf_cnt;
        if (push && full) begin
            if (~(&ovf_cnt)) begin
                ovf_cnt_nxt = ovf_cnt + 1'b1; // Saturates.
            end
        end else if (pop && (|ovf_cnt)) begin
            ovf_cnt_nxt = ovf_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            top     <= '0;
            empty   <= 1'b1;
            ovf_cnt <= '0;
        end else begin
            top     <= top_nxt;
            empty   <= empty_nxt;
            ovf_cnt <= ovf_cnt_nxt;
        end
    end

    // A push writes where the new top will be; a full push lands on top itself.
    always_comb begin
        if (push) begin
            ram_addr = top_nxt;
        end else begin
            ram_addr = top;
        end
    end

    ret_pc_ram #(
        .DEPTH (RAS_SIZE)
    ) u_ret_pc_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (push),
        .wdata (ret_pc_push),
        .rdata (ret_pc_pop)
    );

    // Either nothing to pop, or the top slot was overwritten by deeper calls.
    assign fail = empty | (|ovf_cnt);

endmodule

`default_nettype wire

// File: ret_pc_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module ret_pc_ram #(
    parameter int  DEPTH  = `BPU_RAS_SIZE,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  wire logic              clk,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic              we,
    input  wire bpu_pkg::addr_t    wdata,
    output bpu_pkg::addr_t         rdata
);

    bpu_pkg::addr_t mem [DEPTH];

    assign rdata = mem[addr]; // Asynchronous read port.

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: bpu_pkg.sv
`default_nettype none

`include "bpu_params.svh"

package bpu_pkg;

    typedef logic [`BPU_ADDR_W-1:0] addr_t;

    typedef enum logic [2:0] {
        BR_NONE     = 3'd0,
        BR_COND     = 3'd1, // BEQ, BNE, BLEZ, BGTZ.
        BR_JUMP     = 3'd2, // J.
        BR_CALL     = 3'd3, // JAL.
        BR_RET      = 3'd4, // JR $31.
        BR_INDIRECT = 3'd5  // JR other register, JALR.
    } branch_kind_e;

    // Primary opcode, instr[31:26].
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07
    } opcode_e;

    // SPECIAL function field, instr[5:0].
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_JALR = 6'h09
    } funct_e;

endpackage

`default_nettype wire

// File: bpu_params.svh
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// Width of a fetch address in bits.
`define BPU_ADDR_W 32

// Return address stack entries, a power of two.
`define BPU_RAS_SIZE 8

// Boot vector in kseg1, held as the prediction out of reset.
`define BPU_RESET_PC 32'hbfc00000

`endif
